//--- logic/bbox_iterator.sv
// Bounding box sample iterator top level
`timescale 1ns/1ps

module bbox_iterator (
    input  logic                        clk,
    input  logic                        rst,
    // Upstream triangle, colour and box
    input  raster_geom_pkg::tri_t       tri_in,
    input  raster_geom_pkg::color_vec_t color_in,
    input  raster_geom_pkg::box_t       box_in,
    input  logic                        valid_tri,
    // One-hot multisample mode
    input  logic [3:0]                  sub_sample,
    // High when a new triangle may be taken
    output logic                        accept,
    // Toward the sample test stage
    output raster_geom_pkg::tri_t       tri_out,
    output raster_geom_pkg::color_vec_t color_out,
    output raster_geom_pkg::point_t     sample_out,
    output logic                        sample_valid
);

    // Links between the two datapath blocks
    raster_geom_pkg::point_t sample;
    raster_geom_pkg::coord_t box_min_x;

    iter_ctrl_if ctl_if ();

    // FSM and handshake
    iter_ctrl iter_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .valid_tri    (valid_tri),
        .sub_sample   (sub_sample),
        .accept       (accept),
        .sample_valid (sample_valid),
        .ctl          (ctl_if.ctrl)
    );

    // Stored box and edge flags
    box_edge_check box_edge_check_i (
        .clk       (clk),
        .rst       (rst),
        .box_in    (box_in),
        .sample    (sample),
        .box_min_x (box_min_x),
        .ctl       (ctl_if.edges)
    );

    // Sample walk and payload
    sample_gen sample_gen_i (
        .clk       (clk),
        .rst       (rst),
        .box_in    (box_in),
        .tri_in    (tri_in),
        .color_in  (color_in),
        .box_min_x (box_min_x),
        .sample    (sample),
        .tri_out   (tri_out),
        .color_out (color_out),
        .ctl       (ctl_if.gen)
    );

    assign sample_out = sample;

endmodule

//--- logic/box_edge_check.sv
// Box register with right edge and end of box detection
`timescale 1ns/1ps

module box_edge_check (
    input  logic                    clk,
    input  logic                    rst,
    input  raster_geom_pkg::box_t   box_in,
    input  raster_geom_pkg::point_t sample,
    output raster_geom_pkg::coord_t box_min_x,
    iter_ctrl_if.edges              ctl
);

    raster_geom_pkg::box_t   box_q;
    raster_geom_pkg::coord_t samp_x;
    raster_geom_pkg::coord_t samp_y;
    raster_geom_pkg::coord_t max_x;
    raster_geom_pkg::coord_t max_y;

    // Box is captured together with its triangle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            box_q <= '0;
        end else if (ctl.load) begin
            box_q <= box_in;
        end
    end

    // Named signed views for the compares
    assign samp_x = sample[0];
    assign samp_y = sample[1];
    assign max_x  = box_q[1][0];
    assign max_y  = box_q[1][1];

    // Row wrap target for the sample generator
    assign box_min_x = box_q[0][0];

    // At or past the right column
    assign ctl.at_right = (samp_x >= max_x);

    // Right column of the top row ends the box
    assign ctl.at_end = ctl.at_right && (samp_y >= max_y);

endmodule

//--- logic/iter_ctrl.sv
// Iterator FSM with accept and sample valid registers and the mode latch
`timescale 1ns/1ps

module iter_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       valid_tri,
    input  logic [3:0] sub_sample,
    output logic       accept,
    output logic       sample_valid,
    iter_ctrl_if.ctrl  ctl
);

    raster_ctrl_pkg::iter_state_e state;
    raster_ctrl_pkg::msaa_mode_e  mode_dec;
    raster_ctrl_pkg::msaa_mode_e  mode_q;

    // Upstream triangle is taken while idle
    assign ctl.load = (state == raster_ctrl_pkg::ITER_WAIT) && valid_tri;

    // Keep stepping until the top right sample is reached
    assign ctl.advance = (state == raster_ctrl_pkg::ITER_TEST) && !ctl.at_end;

    assign ctl.mode = mode_q;

    // Mode decode, unknown codes fall back to one sample per pixel
    always_comb begin
        case (sub_sample)
            4'b1000: mode_dec = raster_ctrl_pkg::MSAA_1X;
            4'b0100: mode_dec = raster_ctrl_pkg::MSAA_4X;
            4'b0010: mode_dec = raster_ctrl_pkg::MSAA_16X;
            4'b0001: mode_dec = raster_ctrl_pkg::MSAA_64X;
            default: mode_dec = raster_ctrl_pkg::MSAA_1X;
        endcase
    end

    // State, handshake and mode registers
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= raster_ctrl_pkg::ITER_WAIT;
            accept       <= 1'b1;
            sample_valid <= 1'b0;
            mode_q       <= raster_ctrl_pkg::MSAA_1X;
        end else if (ctl.load) begin
            // First sample goes out on this edge, upstream is held
            state        <= raster_ctrl_pkg::ITER_TEST;
            accept       <= 1'b0;
            sample_valid <= 1'b1;
            // Step stays fixed for the whole box
            mode_q       <= mode_dec;
        end else if ((state == raster_ctrl_pkg::ITER_TEST) && ctl.at_end) begin
            // Last sample was out this cycle, release upstream
            state        <= raster_ctrl_pkg::ITER_WAIT;
            accept       <= 1'b1;
            sample_valid <= 1'b0;
        end
    end

endmodule

//--- logic/iter_ctrl_if.sv
// Control and status interface between the iterator FSM and its datapath
`timescale 1ns/1ps

interface iter_ctrl_if;

    // Take a new triangle and box this cycle
    logic load;
    // Move to the next sample this cycle
    logic advance;
    // Multisample mode latched with the triangle
    raster_ctrl_pkg::msaa_mode_e mode;
    // Current sample sits on the right edge of the box
    logic at_right;
    // Current sample is the last one of the box
    logic at_end;

    // FSM side
    modport ctrl (output load, output advance, output mode, input at_end);

    // Box register and edge compare
    modport edges (input load, output at_right, output at_end);

    // Sample and payload registers
    modport gen (input load, input advance, input mode, input at_right);

endinterface

//--- logic/raster_cfg.svh
// Rasterizer widths, per-triangle counts and the sample step shift
`ifndef RASTER_CFG_SVH
`define RASTER_CFG_SVH

// Width of a coordinate or a colour channel
`define RAST_SIGFIG 24

// Fraction bits in a fixed point coordinate
`define RAST_RADIX 10

// Triangle shape
`define RAST_VERTS 3
`define RAST_AXIS 3

// Colour channels per triangle
`define RAST_COLORS 3

// Shift from one-hot mode code to fixed point step, 1000 gives one pixel
`define RAST_STEP_SHIFT (`RAST_RADIX - 3)

`endif

//--- logic/raster_ctrl_pkg.sv
// Control types: iterator states and multisample modes
package raster_ctrl_pkg;

    // Iterator FSM states
    typedef enum logic {
        ITER_WAIT,
        ITER_TEST
    } iter_state_e;

    // One-hot multisample mode
    // Sample spacing halves with each step toward 64x
    typedef enum logic [3:0] {
        // One sample per pixel
        MSAA_1X  = 4'b1000,
        // Half pixel spacing
        MSAA_4X  = 4'b0100,
        // Quarter pixel spacing
        MSAA_16X = 4'b0010,
        // Eighth pixel spacing
        MSAA_64X = 4'b0001
    } msaa_mode_e;

endpackage

//--- logic/raster_geom_pkg.sv
// Geometry types: coordinates, vertices, triangles, colours, points and boxes
package raster_geom_pkg;

`include "raster_cfg.svh"

    // Signed fixed point, integer part above RAST_RADIX fraction bits
    typedef logic signed [`RAST_SIGFIG-1:0] coord_t;

    // Unsigned colour channel
    typedef logic [`RAST_SIGFIG-1:0] color_t;

    // One vertex, index 0 is x, 1 is y, 2 is z
    typedef coord_t [`RAST_AXIS-1:0] vertex_t;

    // Whole triangle
    typedef vertex_t [`RAST_VERTS-1:0] tri_t;

    // Colour of a triangle, one entry per channel
    typedef color_t [`RAST_COLORS-1:0] color_vec_t;

    // Screen position, index 0 is x and index 1 is y
    typedef coord_t [1:0] point_t;

    // Bounding box, index 0 is the minimum corner, 1 the maximum
    typedef point_t [1:0] box_t;

endpackage

//--- logic/sample_gen.sv
// Sample position stepping and the triangle and colour payload registers
`timescale 1ns/1ps

`include "raster_cfg.svh"

module sample_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  raster_geom_pkg::box_t       box_in,
    input  raster_geom_pkg::tri_t       tri_in,
    input  raster_geom_pkg::color_vec_t color_in,
    input  raster_geom_pkg::coord_t     box_min_x,
    output raster_geom_pkg::point_t     sample,
    output raster_geom_pkg::tri_t       tri_out,
    output raster_geom_pkg::color_vec_t color_out,
    iter_ctrl_if.gen                    ctl
);

    raster_geom_pkg::coord_t step;
    raster_geom_pkg::coord_t samp_x;
    raster_geom_pkg::coord_t samp_y;
    raster_geom_pkg::point_t next_right;
    raster_geom_pkg::point_t next_up;

    // One-hot code shifted into fixed point, 1x gives one pixel
    assign step = raster_geom_pkg::coord_t'(ctl.mode) << `RAST_STEP_SHIFT;

    assign samp_x = sample[0];
    assign samp_y = sample[1];

    // Candidate positions for the next cycle
    always_comb begin
        // Same row, one step right
        next_right[0] = samp_x + step;
        next_right[1] = samp_y;
        // Back to left column, one row up
        next_up[0] = box_min_x;
        next_up[1] = samp_y + step;
    end

    // Sample position register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sample <= '0;
        end else if (ctl.load) begin
            // Start at the lower left corner
            sample <= box_in[0];
        end else if (ctl.advance) begin
            if (ctl.at_right) begin
                sample <= next_up;
            end else begin
                sample <= next_right;
            end
        end
    end

    // Payload follows the inputs while idle
    // and freezes while samples of the box are still coming
    always_ff @(posedge clk) begin
        if (!ctl.advance) begin
            tri_out   <= tri_in;
            color_out <= color_in;
        end
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the bounding box iterator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
    -f verilog.f --top-module bbox_iterator_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vbbox_iterator_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- verif/bbox_iterator_assertions.sv
// Concurrent protocol assertions for the bounding box iterator, bound to its top level
`timescale 1ns/1ps

module bbox_iterator_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    valid_tri,
    input logic                    accept,
    input logic                    sample_valid,
    input raster_geom_pkg::box_t   box_in,
    input raster_geom_pkg::point_t sample_out
);

    // Upstream is held whenever samples go out
    handshake_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(accept && sample_valid))
        else $error("accept and sample_valid high in the same cycle");

    // Lower left corner follows the taken triangle at once
    first_sample: assert property (@(posedge clk) disable iff (rst)
        (accept && valid_tri) |=> sample_valid)
        else $error("no sample after an accepted triangle");

    // Box input is stable during a burst, so compare against it directly
    inside_box: assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> (sample_out[0] >= box_in[0][0]) && (sample_out[0] <= box_in[1][0])
            && (sample_out[1] >= box_in[0][1]) && (sample_out[1] <= box_in[1][1]))
        else $error("valid sample outside the bounding box");

endmodule

//--- verif/bbox_iterator_tb.sv
// Directed testbench for the bounding box iterator with a reference raster walk and watchdog
`timescale 1ns/1ps

`include "raster_cfg.svh"

module bbox_iterator_tb;

    localparam int clk_period_ns = 100;
    localparam int reset_cycles = 16;
    // Sum of columns times rows over every box offered below
    localparam int burst_cycles = 57;
    localparam int margin_cycles = 200;
    localparam int accept_wait_cycles = 20;
    localparam int pixel = 1 << `RAST_RADIX;

    logic                        clk;
    logic                        rst;
    raster_geom_pkg::tri_t       tri_in;
    raster_geom_pkg::color_vec_t color_in;
    raster_geom_pkg::box_t       box_in;
    logic                        valid_tri;
    logic [3:0]                  sub_sample;
    logic                        accept;
    raster_geom_pkg::tri_t       tri_out;
    raster_geom_pkg::color_vec_t color_out;
    raster_geom_pkg::point_t     sample_out;
    logic                        sample_valid;
    int                          error_count;

    tb_clock #(.period_ns(clk_period_ns)) clock_gen_i (.clk(clk));

    bbox_iterator bbox_iterator_i (.*);

    bind bbox_iterator bbox_iterator_assertions bbox_iterator_assertions_i (.*);

    task automatic check(input string name, input logic [215:0] expected,
                         input logic [215:0] actual);
        if (actual !== expected) begin
            $display("FAIL t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    // Sample spacing per mode for 2x2, 4x4 and 8x8 samples per pixel
    function automatic int step_for(input logic [3:0] code);
        case (code)
            4'b0100: return pixel / 2;
            4'b0010: return pixel / 4;
            4'b0001: return pixel / 8;
            default: return pixel;
        endcase
    endfunction

    task automatic new_payload(output raster_geom_pkg::tri_t t,
                               output raster_geom_pkg::color_vec_t c);
        logic [215:0] w;
        w = '0;
        for (int i = 0; i < 7; i++) begin
            w = {w[183:0], $urandom};
        end
        t = w;
        c = w[143:72] ^ {$urandom, $urandom, 8'h5a};
    endtask

    function automatic raster_geom_pkg::box_t make_box(input int cols, input int rows,
                                                      input int step);
        raster_geom_pkg::box_t b;
        int x0;
        int y0;
        // Pixel aligned origin of either sign sits on the grid of every mode
        x0 = (int'($urandom % 512) - 256) * pixel;
        y0 = (int'($urandom % 512) - 256) * pixel;
        b[0][0] = raster_geom_pkg::coord_t'(x0);
        b[0][1] = raster_geom_pkg::coord_t'(y0);
        b[1][0] = raster_geom_pkg::coord_t'(x0 + (cols - 1) * step);
        b[1][1] = raster_geom_pkg::coord_t'(y0 + (rows - 1) * step);
        return b;
    endfunction

    task automatic offer_tri(input raster_geom_pkg::tri_t t, input raster_geom_pkg::color_vec_t c,
                             input raster_geom_pkg::box_t b, input logic [3:0] code);
        @(posedge clk);
        tri_in     <= t;
        color_in   <= c;
        box_in     <= b;
        sub_sample <= code;
        valid_tri  <= 1'b1;
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            check("accept", 216'd1, {215'd0, accept});
            check("sample_valid", 216'd0, {215'd0, sample_valid});
        end
    endtask

    // Reference walk left to right and then one row up from the box minimum x
    task automatic walk_box(input raster_geom_pkg::tri_t t, input raster_geom_pkg::color_vec_t c,
                            input raster_geom_pkg::box_t b, input logic [3:0] code,
                            input logic [3:0] late_code, input int max_waits);
        int step;
        int cols;
        int rows;
        int waits;
        raster_geom_pkg::coord_t exp_x;
        raster_geom_pkg::coord_t exp_y;
        step = step_for(code);
        cols = (int'(b[1][0]) - int'(b[0][0])) / step + 1;
        rows = (int'(b[1][1]) - int'(b[0][1])) / step + 1;
        waits = 0;
        @(negedge clk);
        while (!accept && waits < max_waits) begin
            @(negedge clk);
            waits++;
        end
        if (!accept) begin
            $display("ERROR t=%0t accept stayed low and the triangle was not taken in time",
                     $time);
            error_count++;
        end else begin
            // No sample in the cycle before acceptance
            check("sample_valid", 216'd0, {215'd0, sample_valid});
            @(posedge clk);
            valid_tri <= 1'b0;
            if (late_code != 4'b0000) begin
                sub_sample <= late_code;
            end
            for (int r = 0; r < rows; r++) begin
                for (int x = 0; x < cols; x++) begin
                    @(negedge clk);
                    exp_x = raster_geom_pkg::coord_t'(int'(b[0][0]) + x * step);
                    exp_y = raster_geom_pkg::coord_t'(int'(b[0][1]) + r * step);
                    check("sample_valid", 216'd1, {215'd0, sample_valid});
                    check("accept", 216'd0, {215'd0, accept});
                    check("sample_x", {192'd0, exp_x}, {192'd0, sample_out[0]});
                    check("sample_y", {192'd0, exp_y}, {192'd0, sample_out[1]});
                    check("tri_out", t, tri_out);
                    check("color_out", {144'd0, c}, {144'd0, color_out});
                end
            end
        end
    endtask

    task automatic single_box(input int cols, input int rows, input logic [3:0] code,
                              input logic [3:0] late_code);
        raster_geom_pkg::tri_t       t;
        raster_geom_pkg::color_vec_t c;
        raster_geom_pkg::box_t       b;
        new_payload(t, c);
        b = make_box(cols, rows, step_for(code));
        offer_tri(t, c, b, code);
        walk_box(t, c, b, code, late_code, accept_wait_cycles);
        expect_idle(1);
    endtask

    task automatic idle_after_reset();
        expect_idle(8);
    endtask

    task automatic pixel_box_walk();
        single_box(3, 2, 4'b1000, 4'b0000);
    endtask

    // 16x and 64x also see sub_sample move mid burst
    task automatic msaa_step_sweep();
        single_box(4, 3, 4'b0100, 4'b0000);
        single_box(5, 2, 4'b0010, 4'b1000);
        single_box(3, 3, 4'b0001, 4'b0100);
    endtask

    task automatic illegal_mode_fallback();
        single_box(2, 2, 4'b0110, 4'b0000);
    endtask

    task automatic payload_hold();
        raster_geom_pkg::tri_t       t;
        raster_geom_pkg::tri_t       t2;
        raster_geom_pkg::color_vec_t c;
        raster_geom_pkg::color_vec_t c2;
        raster_geom_pkg::box_t       b;
        new_payload(t, c);
        new_payload(t2, c2);
        b = make_box(4, 2, step_for(4'b0100));
        offer_tri(t, c, b, 4'b0100);
        walk_box(t, c, b, 4'b0100, 4'b0000, accept_wait_cycles);
        // New inputs land on the edge that ends the burst
        @(posedge clk);
        tri_in   <= t2;
        color_in <= c2;
        @(negedge clk);
        check("tri_out", t, tri_out);
        @(negedge clk);
        check("tri_out", t2, tri_out);
        check("color_out", {144'd0, c2}, {144'd0, color_out});
    endtask

    task automatic back_to_back_boxes();
        raster_geom_pkg::tri_t       t [3];
        raster_geom_pkg::color_vec_t c [3];
        raster_geom_pkg::box_t       b [3];
        logic [3:0]                  code [3];
        code[0] = 4'b1000;
        code[1] = 4'b0010;
        code[2] = 4'b0001;
        for (int i = 0; i < 3; i++) begin
            new_payload(t[i], c[i]);
        end
        b[0] = make_box(3, 1, step_for(code[0]));
        b[1] = make_box(2, 2, step_for(code[1]));
        // Minimum equals maximum
        b[2] = make_box(1, 1, step_for(code[2]));
        for (int i = 0; i < 3; i++) begin
            offer_tri(t[i], c[i], b[i], code[i]);
            // Later boxes are taken right after the single idle cycle
            walk_box(t[i], c[i], b[i], code[i], 4'b0000, (i == 0) ? accept_wait_cycles : 0);
        end
        expect_idle(1);
    endtask

    initial begin
        #((reset_cycles + burst_cycles + margin_cycles) * clk_period_ns);
        $display("ERROR simulation timed out before all tests completed");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        error_count = 0;
        void'($urandom(32'h9152_e8cf));
        rst        <= 1'b1;
        valid_tri  <= 1'b0;
        sub_sample <= 4'b1000;
        tri_in     <= '0;
        color_in   <= '0;
        box_in     <= '0;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        idle_after_reset();
        pixel_box_walk();
        msaa_step_sweep();
        illegal_mode_fallback();
        payload_hold();
        back_to_back_boxes();
        $display("Tests done, error count %0d", error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clock.sv
// Free running clock source for the testbench
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial clk = 1'b0;

    // Half period low, half period high
    always #(period_ns / 2) clk = ~clk;

endmodule

//--- verilog.f
+incdir+logic
logic/raster_geom_pkg.sv
logic/raster_ctrl_pkg.sv
logic/iter_ctrl_if.sv
logic/iter_ctrl.sv
logic/box_edge_check.sv
logic/sample_gen.sv
logic/bbox_iterator.sv
verif/tb_clock.sv
verif/bbox_iterator_assertions.sv
verif/bbox_iterator_tb.sv
